// File: build.f
rv_dec_pkg.sv
rv_dec_classify.sv
rv_dec_imm_gen.sv
rv_dec_exec_ctrl.sv
rv_dec_mem_wb_ctrl.sv
rv_decoder.sv
rv_decoder_asserts.sv
tb_rv_decoder.sv

// File: rv_dec_classify.sv
`timescale 1ns/1ps

module rv_dec_classify (
    input  logic [rv_dec_pkg::XLEN-1:0] instr_i,
    output rv_dec_pkg::instr_kind_e     kind_o,
    output rv_dec_pkg::instr_fmt_e      fmt_o,
    output rv_dec_pkg::reg_use_t        reg_use_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm12;
    logic        sys_regs_zero;

    assign opcode        = instr_i[6:0];
    assign funct3        = instr_i[14:12];
    assign funct7        = instr_i[31:25];
    assign imm12         = instr_i[31:20];
    assign sys_regs_zero = (instr_i[19:15] == '0) && (instr_i[11:7] == '0);

    always_comb begin
        kind_o = rv_dec_pkg::KIND_ILLEGAL;
        case (opcode)
            rv_dec_pkg::OP_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: kind_o = rv_dec_pkg::KIND_ADD;
                    {7'b0100000, 3'b000}: kind_o = rv_dec_pkg::KIND_SUB;
                    {7'b0000000, 3'b111}: kind_o = rv_dec_pkg::KIND_AND;
                    {7'b0000000, 3'b110}: kind_o = rv_dec_pkg::KIND_OR;
                    {7'b0000000, 3'b100}: kind_o = rv_dec_pkg::KIND_XOR;
                    {7'b0000000, 3'b001}: kind_o = rv_dec_pkg::KIND_SLL;
                    {7'b0000000, 3'b101}: kind_o = rv_dec_pkg::KIND_SRL;
                    {7'b0100000, 3'b101}: kind_o = rv_dec_pkg::KIND_SRA;
                    {7'b0000000, 3'b011}: kind_o = rv_dec_pkg::KIND_SLTU;
                    default: ;
                endcase
            end
            rv_dec_pkg::OP_OP_IMM: begin
                case (funct3)
                    3'b000: kind_o = rv_dec_pkg::KIND_ADDI;
                    3'b111: kind_o = rv_dec_pkg::KIND_ANDI;
                    3'b110: kind_o = rv_dec_pkg::KIND_ORI;
                    3'b100: kind_o = rv_dec_pkg::KIND_XORI;
                    3'b001: if (funct7 == 7'b0000000) kind_o = rv_dec_pkg::KIND_SLLI;
                    3'b101: begin
                        if (funct7 == 7'b0000000) kind_o = rv_dec_pkg::KIND_SRLI;
                        else if (funct7 == 7'b0100000) kind_o = rv_dec_pkg::KIND_SRAI;
                    end
                    default: ;                     // No sltiu in this subset
                endcase
            end
            rv_dec_pkg::OP_LUI:   kind_o = rv_dec_pkg::KIND_LUI;
            rv_dec_pkg::OP_AUIPC: kind_o = rv_dec_pkg::KIND_AUIPC;
            rv_dec_pkg::OP_LOAD: begin
                if (funct3 == 3'b010) kind_o = rv_dec_pkg::KIND_LW;
                else if (funct3 == 3'b100) kind_o = rv_dec_pkg::KIND_LBU;
            end
            rv_dec_pkg::OP_STORE: if (funct3 == 3'b010) kind_o = rv_dec_pkg::KIND_SW;
            rv_dec_pkg::OP_BRANCH: begin
                case (funct3)
                    3'b000: kind_o = rv_dec_pkg::KIND_BEQ;
                    3'b001: kind_o = rv_dec_pkg::KIND_BNE;
                    3'b100: kind_o = rv_dec_pkg::KIND_BLT;
                    3'b101: kind_o = rv_dec_pkg::KIND_BGE;
                    3'b110: kind_o = rv_dec_pkg::KIND_BLTU;
                    3'b111: kind_o = rv_dec_pkg::KIND_BGEU;
                    default: ;
                endcase
            end
            rv_dec_pkg::OP_JAL:  kind_o = rv_dec_pkg::KIND_JAL;
            rv_dec_pkg::OP_JALR: if (funct3 == 3'b000) kind_o = rv_dec_pkg::KIND_JALR;
            rv_dec_pkg::OP_MISC_MEM: if (funct3 == 3'b000) kind_o = rv_dec_pkg::KIND_FENCE;
            rv_dec_pkg::OP_SYSTEM: begin
                if (funct3 == 3'b000 && sys_regs_zero) begin
                    if (imm12 == 12'h000) kind_o = rv_dec_pkg::KIND_ECALL;
                    else if (imm12 == 12'h001) kind_o = rv_dec_pkg::KIND_EBREAK;
                    else if (imm12 == 12'h302) kind_o = rv_dec_pkg::KIND_MRET;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (kind_o)
            rv_dec_pkg::KIND_ADD, rv_dec_pkg::KIND_SUB, rv_dec_pkg::KIND_AND,
            rv_dec_pkg::KIND_OR, rv_dec_pkg::KIND_XOR, rv_dec_pkg::KIND_SLL,
            rv_dec_pkg::KIND_SRL, rv_dec_pkg::KIND_SRA, rv_dec_pkg::KIND_SLTU:
                fmt_o = rv_dec_pkg::FMT_R;
            rv_dec_pkg::KIND_ADDI, rv_dec_pkg::KIND_ANDI, rv_dec_pkg::KIND_ORI,
            rv_dec_pkg::KIND_XORI, rv_dec_pkg::KIND_SLLI, rv_dec_pkg::KIND_SRLI,
            rv_dec_pkg::KIND_SRAI, rv_dec_pkg::KIND_LW, rv_dec_pkg::KIND_LBU,
            rv_dec_pkg::KIND_JALR:
                fmt_o = rv_dec_pkg::FMT_I;
            rv_dec_pkg::KIND_SW: fmt_o = rv_dec_pkg::FMT_S;
            rv_dec_pkg::KIND_BEQ, rv_dec_pkg::KIND_BNE, rv_dec_pkg::KIND_BLT,
            rv_dec_pkg::KIND_BGE, rv_dec_pkg::KIND_BLTU, rv_dec_pkg::KIND_BGEU:
                fmt_o = rv_dec_pkg::FMT_B;
            rv_dec_pkg::KIND_LUI, rv_dec_pkg::KIND_AUIPC: fmt_o = rv_dec_pkg::FMT_U;
            rv_dec_pkg::KIND_JAL: fmt_o = rv_dec_pkg::FMT_J;
            rv_dec_pkg::KIND_FENCE, rv_dec_pkg::KIND_ECALL, rv_dec_pkg::KIND_EBREAK,
            rv_dec_pkg::KIND_MRET:
                fmt_o = rv_dec_pkg::FMT_SYS;
            default: fmt_o = rv_dec_pkg::FMT_ILLEGAL;
        endcase
    end

    // Register use follows the format alone
    always_comb begin
        reg_use_o.rs1         = instr_i[19:15];
        reg_use_o.rs2         = instr_i[24:20];
        reg_use_o.rd          = instr_i[11:7];
        reg_use_o.rs1_used    = fmt_o inside {rv_dec_pkg::FMT_R, rv_dec_pkg::FMT_I,
                                              rv_dec_pkg::FMT_S, rv_dec_pkg::FMT_B};
        reg_use_o.rs2_used    = fmt_o inside {rv_dec_pkg::FMT_R, rv_dec_pkg::FMT_S,
                                              rv_dec_pkg::FMT_B};
        reg_use_o.rd_write_en = fmt_o inside {rv_dec_pkg::FMT_R, rv_dec_pkg::FMT_I,
                                              rv_dec_pkg::FMT_U, rv_dec_pkg::FMT_J};
        reg_use_o.wb_en       = reg_use_o.rd_write_en && (instr_i[11:7] != '0);
    end

endmodule

// File: rv_dec_exec_ctrl.sv
`timescale 1ns/1ps

module rv_dec_exec_ctrl (
    input  rv_dec_pkg::instr_kind_e kind_i,
    output rv_dec_pkg::exec_ctrl_t  exec_o
);

    always_comb begin
        exec_o.alu_op       = rv_dec_pkg::ALU_NONE;
        exec_o.alu_in2_sel  = rv_dec_pkg::ALU_IN2_ZERO;
        exec_o.cmp_op       = rv_dec_pkg::CMP_NONE;
        exec_o.adder_use    = rv_dec_pkg::ADDER_NONE;
        exec_o.add_in1_sel  = rv_dec_pkg::ADD_IN1_ZERO;
        exec_o.add_in2_sel  = rv_dec_pkg::ADD_IN2_ZERO;
        exec_o.add_postproc = 1'b0;

        case (kind_i)
            rv_dec_pkg::KIND_ADD, rv_dec_pkg::KIND_ADDI: exec_o.alu_op = rv_dec_pkg::ALU_ADD;
            rv_dec_pkg::KIND_SUB:                        exec_o.alu_op = rv_dec_pkg::ALU_SUB;
            rv_dec_pkg::KIND_AND, rv_dec_pkg::KIND_ANDI: exec_o.alu_op = rv_dec_pkg::ALU_AND;
            rv_dec_pkg::KIND_OR, rv_dec_pkg::KIND_ORI:   exec_o.alu_op = rv_dec_pkg::ALU_OR;
            rv_dec_pkg::KIND_XOR, rv_dec_pkg::KIND_XORI: exec_o.alu_op = rv_dec_pkg::ALU_XOR;
            rv_dec_pkg::KIND_SLL, rv_dec_pkg::KIND_SLLI: exec_o.alu_op = rv_dec_pkg::ALU_SLL;
            rv_dec_pkg::KIND_SRL, rv_dec_pkg::KIND_SRLI: exec_o.alu_op = rv_dec_pkg::ALU_SRL;
            rv_dec_pkg::KIND_SRA, rv_dec_pkg::KIND_SRAI: exec_o.alu_op = rv_dec_pkg::ALU_SRA;
            rv_dec_pkg::KIND_SLTU:                       exec_o.alu_op = rv_dec_pkg::ALU_SLTU;
            default: ;
        endcase

        case (kind_i)
            rv_dec_pkg::KIND_ADD, rv_dec_pkg::KIND_SUB, rv_dec_pkg::KIND_AND,
            rv_dec_pkg::KIND_OR, rv_dec_pkg::KIND_XOR, rv_dec_pkg::KIND_SLL,
            rv_dec_pkg::KIND_SRL, rv_dec_pkg::KIND_SRA, rv_dec_pkg::KIND_SLTU:
                exec_o.alu_in2_sel = rv_dec_pkg::ALU_IN2_RS2;
            rv_dec_pkg::KIND_ADDI, rv_dec_pkg::KIND_ANDI, rv_dec_pkg::KIND_ORI,
            rv_dec_pkg::KIND_XORI:
                exec_o.alu_in2_sel = rv_dec_pkg::ALU_IN2_IMM_I;
            rv_dec_pkg::KIND_SLLI, rv_dec_pkg::KIND_SRLI, rv_dec_pkg::KIND_SRAI:
                exec_o.alu_in2_sel = rv_dec_pkg::ALU_IN2_IMM_SHAMT;
            default: ;
        endcase

        // Comparator and branch target
        case (kind_i)
            rv_dec_pkg::KIND_BEQ:  exec_o.cmp_op = rv_dec_pkg::CMP_EQ;
            rv_dec_pkg::KIND_BNE:  exec_o.cmp_op = rv_dec_pkg::CMP_NE;
            rv_dec_pkg::KIND_BLT:  exec_o.cmp_op = rv_dec_pkg::CMP_LT;
            rv_dec_pkg::KIND_BGE:  exec_o.cmp_op = rv_dec_pkg::CMP_GE;
            rv_dec_pkg::KIND_BLTU: exec_o.cmp_op = rv_dec_pkg::CMP_LTU;
            rv_dec_pkg::KIND_BGEU: exec_o.cmp_op = rv_dec_pkg::CMP_GEU;
            default: ;
        endcase
        exec_o.cmp_out_used = (exec_o.cmp_op != rv_dec_pkg::CMP_NONE);

        case (kind_i)
            rv_dec_pkg::KIND_LW, rv_dec_pkg::KIND_LBU, rv_dec_pkg::KIND_SW: begin
                exec_o.adder_use   = rv_dec_pkg::ADDER_EA;
                exec_o.add_in1_sel = rv_dec_pkg::ADD_IN1_RS1;
                exec_o.add_in2_sel = (kind_i == rv_dec_pkg::KIND_SW) ?
                                     rv_dec_pkg::ADD_IN2_IMM_S : rv_dec_pkg::ADD_IN2_IMM_I;
            end
            rv_dec_pkg::KIND_AUIPC: begin
                exec_o.adder_use   = rv_dec_pkg::ADDER_PC_REL;
                exec_o.add_in1_sel = rv_dec_pkg::ADD_IN1_PC;
                exec_o.add_in2_sel = rv_dec_pkg::ADD_IN2_UIMM;
            end
            rv_dec_pkg::KIND_JAL: begin
                exec_o.adder_use   = rv_dec_pkg::ADDER_J_TARGET;
                exec_o.add_in1_sel = rv_dec_pkg::ADD_IN1_PC;
                exec_o.add_in2_sel = rv_dec_pkg::ADD_IN2_IMM_J;
            end
            rv_dec_pkg::KIND_JALR: begin
                exec_o.adder_use    = rv_dec_pkg::ADDER_IND_TARGET;
                exec_o.add_in1_sel  = rv_dec_pkg::ADD_IN1_RS1;
                exec_o.add_in2_sel  = rv_dec_pkg::ADD_IN2_IMM_I;
                exec_o.add_postproc = 1'b1;        // Target LSB forced to 0
            end
            default: begin
                if (exec_o.cmp_out_used) begin
                    exec_o.adder_use   = rv_dec_pkg::ADDER_BR_TARGET;
                    exec_o.add_in1_sel = rv_dec_pkg::ADD_IN1_PC;
                    exec_o.add_in2_sel = rv_dec_pkg::ADD_IN2_IMM_B;
                end
            end
        endcase

        exec_o.alu_en      = (exec_o.alu_op != rv_dec_pkg::ALU_NONE);
        exec_o.alu_in1_sel = exec_o.alu_en ? rv_dec_pkg::ALU_IN1_RS1 : rv_dec_pkg::ALU_IN1_ZERO;
    end

endmodule

// File: rv_dec_imm_gen.sv
`timescale 1ns/1ps

module rv_dec_imm_gen (
    input  logic [rv_dec_pkg::XLEN-1:0] instr_i,
    input  rv_dec_pkg::instr_kind_e     kind_i,
    output logic [rv_dec_pkg::XLEN-1:0] imm_o
);

    logic [rv_dec_pkg::XLEN-1:0] imm_i;
    logic [rv_dec_pkg::XLEN-1:0] imm_s;
    logic [rv_dec_pkg::XLEN-1:0] imm_b;
    logic [rv_dec_pkg::XLEN-1:0] imm_u;
    logic [rv_dec_pkg::XLEN-1:0] imm_j;
    logic [rv_dec_pkg::XLEN-1:0] imm_shamt;

    assign imm_i     = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b     = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u     = {instr_i[31:12], 12'b0};
    assign imm_j     = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_shamt = {27'b0, instr_i[24:20]};

    always_comb begin
        case (kind_i)
            rv_dec_pkg::KIND_ADDI, rv_dec_pkg::KIND_ANDI, rv_dec_pkg::KIND_ORI,
            rv_dec_pkg::KIND_XORI, rv_dec_pkg::KIND_LW, rv_dec_pkg::KIND_LBU,
            rv_dec_pkg::KIND_JALR:
                imm_o = imm_i;
            rv_dec_pkg::KIND_SLLI, rv_dec_pkg::KIND_SRLI, rv_dec_pkg::KIND_SRAI:
                imm_o = imm_shamt;
            rv_dec_pkg::KIND_SW: imm_o = imm_s;
            rv_dec_pkg::KIND_BEQ, rv_dec_pkg::KIND_BNE, rv_dec_pkg::KIND_BLT,
            rv_dec_pkg::KIND_BGE, rv_dec_pkg::KIND_BLTU, rv_dec_pkg::KIND_BGEU:
                imm_o = imm_b;
            rv_dec_pkg::KIND_LUI, rv_dec_pkg::KIND_AUIPC: imm_o = imm_u;
            rv_dec_pkg::KIND_JAL: imm_o = imm_j;
            default: imm_o = '0;                   // R-type, fence, system, illegal
        endcase
    end

endmodule

// File: rv_dec_mem_wb_ctrl.sv
`timescale 1ns/1ps

module rv_dec_mem_wb_ctrl (
    input  rv_dec_pkg::instr_kind_e kind_i,
    output rv_dec_pkg::mem_wb_t     memwb_o
);

    always_comb begin
        case (kind_i)
            rv_dec_pkg::KIND_ADD, rv_dec_pkg::KIND_SUB, rv_dec_pkg::KIND_AND,
            rv_dec_pkg::KIND_OR, rv_dec_pkg::KIND_XOR, rv_dec_pkg::KIND_SLL,
            rv_dec_pkg::KIND_SRL, rv_dec_pkg::KIND_SRA, rv_dec_pkg::KIND_SLTU,
            rv_dec_pkg::KIND_ADDI, rv_dec_pkg::KIND_ANDI, rv_dec_pkg::KIND_ORI,
            rv_dec_pkg::KIND_XORI, rv_dec_pkg::KIND_SLLI, rv_dec_pkg::KIND_SRLI,
            rv_dec_pkg::KIND_SRAI:
                memwb_o.wb_sel = rv_dec_pkg::WB_ALU;
            rv_dec_pkg::KIND_LUI:   memwb_o.wb_sel = rv_dec_pkg::WB_IMM_LUI;
            rv_dec_pkg::KIND_AUIPC: memwb_o.wb_sel = rv_dec_pkg::WB_ADDER;
            rv_dec_pkg::KIND_LW:    memwb_o.wb_sel = rv_dec_pkg::WB_LOAD;
            rv_dec_pkg::KIND_LBU:   memwb_o.wb_sel = rv_dec_pkg::WB_LOAD_ZEXT8;
            rv_dec_pkg::KIND_JAL, rv_dec_pkg::KIND_JALR:
                memwb_o.wb_sel = rv_dec_pkg::WB_PC_PLUS4; // Link address
            default: memwb_o.wb_sel = rv_dec_pkg::WB_NONE;
        endcase

        memwb_o.mem_read      = (kind_i == rv_dec_pkg::KIND_LW) ||
                                (kind_i == rv_dec_pkg::KIND_LBU);
        memwb_o.mem_write     = (kind_i == rv_dec_pkg::KIND_SW);
        memwb_o.mem_wdata_sel = memwb_o.mem_write;         // Store data from rs2
        memwb_o.mem_wstrb     = {4{memwb_o.mem_write}};    // Word stores only
    end

endmodule

// File: rv_dec_pkg.sv
package rv_dec_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Major opcodes
    localparam logic [6:0] OP_OP       = 7'b0110011;
    localparam logic [6:0] OP_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI      = 7'b0110111;
    localparam logic [6:0] OP_AUIPC    = 7'b0010111;
    localparam logic [6:0] OP_LOAD     = 7'b0000011;
    localparam logic [6:0] OP_STORE    = 7'b0100011;
    localparam logic [6:0] OP_BRANCH   = 7'b1100011;
    localparam logic [6:0] OP_JAL      = 7'b1101111;
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM   = 7'b1110011;

    typedef enum logic [5:0] {
        KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_XOR,
        KIND_SLL, KIND_SRL, KIND_SRA, KIND_SLTU,
        KIND_ADDI, KIND_ANDI, KIND_ORI, KIND_XORI,
        KIND_SLLI, KIND_SRLI, KIND_SRAI,
        KIND_LUI, KIND_AUIPC, KIND_LW, KIND_LBU, KIND_SW,
        KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU,
        KIND_JAL, KIND_JALR,
        KIND_FENCE, KIND_ECALL, KIND_EBREAK, KIND_MRET,
        KIND_ILLEGAL
    } instr_kind_e;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_SYS, FMT_ILLEGAL
    } instr_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLTU = 4'd8,
        ALU_NONE = 4'hF
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU, CMP_NONE
    } cmp_op_e;

    typedef enum logic [1:0] {
        ALU_IN1_ZERO, ALU_IN1_RS1
    } alu_in1_e;

    typedef enum logic [1:0] {
        ALU_IN2_ZERO, ALU_IN2_RS2, ALU_IN2_IMM_I, ALU_IN2_IMM_SHAMT
    } alu_in2_e;

    typedef enum logic [2:0] {
        ADDER_NONE, ADDER_EA, ADDER_PC_REL, ADDER_BR_TARGET, ADDER_IND_TARGET, ADDER_J_TARGET
    } adder_use_e;

    typedef enum logic [1:0] {
        ADD_IN1_ZERO, ADD_IN1_RS1, ADD_IN1_PC
    } add_in1_e;

    typedef enum logic [2:0] {
        ADD_IN2_ZERO, ADD_IN2_IMM_I, ADD_IN2_IMM_S, ADD_IN2_IMM_B, ADD_IN2_IMM_J, ADD_IN2_UIMM
    } add_in2_e;

    typedef enum logic [2:0] {
        WB_NONE, WB_ALU, WB_IMM_LUI, WB_ADDER, WB_LOAD, WB_LOAD_ZEXT8, WB_PC_PLUS4
    } wb_sel_e;

    typedef struct packed {
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic              rs1_used;
        logic              rs2_used;
        logic              rd_write_en;
        logic              wb_en;         // rd_write_en with rd != x0
    } reg_use_t;

    typedef struct packed {
        logic       alu_en;
        alu_op_e    alu_op;
        alu_in1_e   alu_in1_sel;
        alu_in2_e   alu_in2_sel;
        cmp_op_e    cmp_op;
        logic       cmp_out_used;
        adder_use_e adder_use;
        add_in1_e   add_in1_sel;
        add_in2_e   add_in2_sel;
        logic       add_postproc;         // Clear LSB of adder result
    } exec_ctrl_t;

    typedef struct packed {
        wb_sel_e    wb_sel;
        logic       mem_read;
        logic       mem_write;
        logic       mem_wdata_sel;        // 1 selects rs2
        logic [3:0] mem_wstrb;
    } mem_wb_t;

    typedef struct packed {
        logic            illegal;
        instr_fmt_e      fmt;
        reg_use_t        regs;
        exec_ctrl_t      exec;
        mem_wb_t         memwb;
        logic [XLEN-1:0] imm;
    } decode_t;

endpackage

// File: rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [rv_dec_pkg::XLEN-1:0] instr_i,
    input  logic                        instr_valid_i,
    output rv_dec_pkg::decode_t         dec_o,
    output logic                        dec_valid_o
);

    rv_dec_pkg::instr_kind_e     kind;
    rv_dec_pkg::instr_fmt_e      fmt;
    rv_dec_pkg::reg_use_t        reg_use;
    rv_dec_pkg::exec_ctrl_t      exec_ctrl;
    rv_dec_pkg::mem_wb_t         memwb;
    logic [rv_dec_pkg::XLEN-1:0] imm;
    rv_dec_pkg::decode_t         dec_next;

    rv_dec_classify i_classify (
        .instr_i   (instr_i),
        .kind_o    (kind),
        .fmt_o     (fmt),
        .reg_use_o (reg_use)
    );

    rv_dec_imm_gen i_imm_gen (
        .instr_i (instr_i),
        .kind_i  (kind),
        .imm_o   (imm)
    );

    rv_dec_exec_ctrl i_exec_ctrl (
        .kind_i (kind),
        .exec_o (exec_ctrl)
    );

    rv_dec_mem_wb_ctrl i_mem_wb_ctrl (
        .kind_i  (kind),
        .memwb_o (memwb)
    );

    assign dec_next = '{illegal: (kind == rv_dec_pkg::KIND_ILLEGAL), fmt: fmt, regs: reg_use,
                        exec: exec_ctrl, memwb: memwb, imm: imm};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_valid_o         <= 1'b0;
            dec_o               <= '0;             // All enables low
            dec_o.illegal       <= 1'b1;
            dec_o.fmt           <= rv_dec_pkg::FMT_ILLEGAL;
            dec_o.exec.alu_op   <= rv_dec_pkg::ALU_NONE;
            dec_o.exec.cmp_op   <= rv_dec_pkg::CMP_NONE;
        end else begin
            dec_valid_o <= instr_valid_i;
            if (instr_valid_i) begin
                dec_o <= dec_next;                 // Holds between strobes
            end
        end
    end

endmodule

// File: rv_decoder_asserts.sv
`timescale 1ns/1ps

module rv_decoder_asserts (
    input logic                clk_i,
    input logic                rst_i,
    input logic                instr_valid_i,
    input rv_dec_pkg::decode_t dec_i,
    input logic                dec_valid_i
);

    valid_follows_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
        1'b1 |=> (dec_valid_i == $past(instr_valid_i)))
        else $error("dec_valid_o is not instr_valid_i delayed by one cycle");

    valid_low_in_reset: assert property (@(posedge clk_i) rst_i |=> !dec_valid_i)
        else $error("dec_valid_o is high during reset");

    // Illegal bundles must not enable any unit
    illegal_no_enables: assert property (@(posedge clk_i) disable iff (rst_i)
        dec_i.illegal |-> !(dec_i.exec.alu_en || dec_i.exec.cmp_out_used
                            || dec_i.memwb.mem_read || dec_i.memwb.mem_write
                            || dec_i.regs.rd_write_en || dec_i.regs.wb_en))
        else $error("illegal bundle has an enable set");

    write_full_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
        dec_i.memwb.mem_write |-> (dec_i.memwb.mem_wstrb == 4'hF))
        else $error("mem_write without a full byte strobe");

endmodule

bind rv_decoder rv_decoder_asserts i_rv_decoder_asserts (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .dec_i         (dec_o),
    .dec_valid_i   (dec_valid_o)
);

// File: rv_decoder_cases.txt
// test instr illegal fmt imm alu_op cmp_op adder_use wb_sel
// mem_read mem_write mem_wstrb rs1_used rs2_used wb_en, all in hex
2 003100B3 0 0 00000000 0 6 0 1 0 0 0 1 1 1
2 403100B3 0 0 00000000 1 6 0 1 0 0 0 1 1 1
2 003170B3 0 0 00000000 2 6 0 1 0 0 0 1 1 1
2 003160B3 0 0 00000000 3 6 0 1 0 0 0 1 1 1
2 003140B3 0 0 00000000 4 6 0 1 0 0 0 1 1 1
2 003110B3 0 0 00000000 5 6 0 1 0 0 0 1 1 1
2 003150B3 0 0 00000000 6 6 0 1 0 0 0 1 1 1
2 403150B3 0 0 00000000 7 6 0 1 0 0 0 1 1 1
2 003130B3 0 0 00000000 8 6 0 1 0 0 0 1 1 1
2 00310033 0 0 00000000 0 6 0 1 0 0 0 1 1 0
2 FFF10093 0 1 FFFFFFFF 0 6 0 1 0 0 0 1 0 1
2 7F017093 0 1 000007F0 2 6 0 1 0 0 0 1 0 1
2 80016093 0 1 FFFFF800 3 6 0 1 0 0 0 1 0 1
2 55514093 0 1 00000555 4 6 0 1 0 0 0 1 0 1
2 00511093 0 1 00000005 5 6 0 1 0 0 0 1 0 1
2 01F15093 0 1 0000001F 6 6 0 1 0 0 0 1 0 1
2 40715093 0 1 00000007 7 6 0 1 0 0 0 1 0 1
3 00832283 0 1 00000008 F 6 1 4 1 0 0 1 0 1
3 FFC34283 0 1 FFFFFFFC F 6 1 5 1 0 0 1 0 1
3 00732623 0 2 0000000C F 6 1 0 0 1 F 1 1 0
3 12345537 0 4 12345000 F 6 0 2 0 0 0 0 0 1
3 FFFFF597 0 4 FFFFF000 F 6 2 3 0 0 0 0 0 1
3 001000EF 0 5 00000800 F 6 5 6 0 0 0 0 0 1
3 004280E7 0 1 00000004 F 6 4 6 0 0 0 1 0 1
4 00208863 0 3 00000010 F 0 3 0 0 0 0 1 1 0
4 00209863 0 3 00000010 F 1 3 0 0 0 0 1 1 0
4 FE20CCE3 0 3 FFFFFFF8 F 2 3 0 0 0 0 1 1 0
4 0020D0E3 0 3 00000800 F 3 3 0 0 0 0 1 1 0
4 0020E263 0 3 00000004 F 4 3 0 0 0 0 1 1 0
4 8020F063 0 3 FFFFF000 F 5 3 0 0 0 0 1 1 0
5 0FF0000F 0 6 00000000 F 6 0 0 0 0 0 0 0 0
5 00000073 0 6 00000000 F 6 0 0 0 0 0 0 0 0
5 00100073 0 6 00000000 F 6 0 0 0 0 0 0 0 0
5 30200073 0 6 00000000 F 6 0 0 0 0 0 0 0 0
5 023100B3 1 7 00000000 F 6 0 0 0 0 0 0 0 0
5 00013093 1 7 00000000 F 6 0 0 0 0 0 0 0 0
5 000000F3 1 7 00000000 F 6 0 0 0 0 0 0 0 0
5 0000007F 1 7 00000000 F 6 0 0 0 0 0 0 0 0

// File: tb_rv_decoder.sv
`timescale 1ns/1ps

module tb_rv_decoder;

    localparam int NUM_CASES  = 38;
    localparam int CASE_W     = 15;                // Words per case line
    localparam int BURST_LEN  = 16;
    localparam int CLK_PERIOD = 10;

    logic                clk;
    logic                rst;
    logic [31:0]         instr;
    logic                instr_valid;
    rv_dec_pkg::decode_t dec;
    logic                dec_valid;

    logic [31:0] case_mem [0:NUM_CASES*CASE_W-1];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          seed;

    rv_decoder i_rv_decoder (
        .clk_i         (clk),
        .rst_i         (rst),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .dec_o         (dec),
        .dec_valid_o   (dec_valid)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // Compares the registered bundle with case line idx
    task automatic check_bundle(input int idx);
        int b;
        b = idx * CASE_W;
        check_field("dec_valid_o", 32'h1, dec_valid);
        check_field("dec_o.illegal", case_mem[b+2], dec.illegal);
        check_field("dec_o.fmt", case_mem[b+3], dec.fmt);
        check_field("dec_o.imm", case_mem[b+4], dec.imm);
        check_field("dec_o.exec.alu_op", case_mem[b+5], dec.exec.alu_op);
        check_field("dec_o.exec.cmp_op", case_mem[b+6], dec.exec.cmp_op);
        check_field("dec_o.exec.adder_use", case_mem[b+7], dec.exec.adder_use);
        check_field("dec_o.memwb.wb_sel", case_mem[b+8], dec.memwb.wb_sel);
        check_field("dec_o.memwb.mem_read", case_mem[b+9], dec.memwb.mem_read);
        check_field("dec_o.memwb.mem_write", case_mem[b+10], dec.memwb.mem_write);
        check_field("dec_o.memwb.mem_wstrb", case_mem[b+11], dec.memwb.mem_wstrb);
        check_field("dec_o.regs.rs1_used", case_mem[b+12], dec.regs.rs1_used);
        check_field("dec_o.regs.rs2_used", case_mem[b+13], dec.regs.rs2_used);
        check_field("dec_o.regs.wb_en", case_mem[b+14], dec.regs.wb_en);
    endtask

    task automatic apply_case(input int idx);
        @(negedge clk);
        instr       = case_mem[idx*CASE_W+1];
        instr_valid = 1'b1;
        @(negedge clk);
        instr_valid = 1'b0;                        // One-cycle strobe
        check_bundle(idx);
    endtask

    task automatic run_group(input int group);
        int n;
        n = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            if (case_mem[i*CASE_W] == group) begin
                apply_case(i);
                n++;
            end
        end
        if (n == 0) begin
            $display("no cases for test %0d were found in the case file", group);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        #((((NUM_CASES + BURST_LEN) * 20) + 100) * CLK_PERIOD);
        $display("watchdog timeout, the run did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        int err_before;
        int picks [BURST_LEN];
        clk          = 1'b0;
        rst          = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 68;
        $readmemh("rv_decoder_cases.txt", case_mem);

        err_before  = errors;
        instr       = case_mem[1];                 // Must not load while in reset
        instr_valid = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_field("dec_valid_o", 32'h0, dec_valid);
        end
        rst         = 1'b0;
        instr_valid = 1'b0;
        check_field("dec_o.illegal", 32'h1, dec.illegal);
        check_field("dec_o.exec.alu_en", 32'h0, dec.exec.alu_en);
        check_field("dec_o.exec.cmp_out_used", 32'h0, dec.exec.cmp_out_used);
        check_field("dec_o.memwb.mem_read", 32'h0, dec.memwb.mem_read);
        check_field("dec_o.memwb.mem_write", 32'h0, dec.memwb.mem_write);
        check_field("dec_o.regs.rd_write_en", 32'h0, dec.regs.rd_write_en);
        check_field("dec_o.regs.wb_en", 32'h0, dec.regs.wb_en);
        report_test(1, "reset", err_before);

        err_before = errors;
        run_group(2);
        report_test(2, "alu decode", err_before);
        err_before = errors;
        run_group(3);
        report_test(3, "memory, upper immediate and jump decode", err_before);
        err_before = errors;
        run_group(4);
        report_test(4, "branch decode", err_before);
        err_before = errors;
        run_group(5);
        report_test(5, "system and illegal decode", err_before);

        err_before = errors;
        for (int k = 0; k < BURST_LEN; k++) begin
            picks[k] = $unsigned($random(seed)) % NUM_CASES;
        end
        for (int k = 0; k <= BURST_LEN; k++) begin
            @(negedge clk);
            if (k > 0) begin
                check_bundle(picks[k-1]);          // Result of previous cycle
            end
            if (k < BURST_LEN) begin
                instr       = case_mem[picks[k]*CASE_W+1];
                instr_valid = 1'b1;
            end else begin
                instr_valid = 1'b0;
            end
        end
        @(negedge clk);
        check_field("dec_valid_o", 32'h0, dec_valid);
        report_test(6, "back-to-back throughput", err_before);

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
